//--- rtl/mem_axil_pkg.sv
`default_nettype none

package mem_axil_pkg;

  // Bus widths
  localparam int ADDR_W      = 32;
  localparam int FILL_W      = 64;
  localparam int AXIL_DATA_W = 64;
  localparam int STRB_W      = AXIL_DATA_W / 8;
  localparam int OFFS_W      = 3;
  localparam int PAYLOAD_W   = 8;

  // Forward message types
  typedef enum logic [1:0]
  {
    e_mem_rd    = 2'b00,
    e_mem_wr    = 2'b01,
    e_mem_uc_rd = 2'b10,
    e_mem_uc_wr = 2'b11
  } mem_msg_e;

  // Access size as log2 of the byte count
  typedef enum logic [1:0]
  {
    e_size_1 = 2'b00,
    e_size_2 = 2'b01,
    e_size_4 = 2'b10,
    e_size_8 = 2'b11
  } mem_size_e;

  // Header shared by forward and reverse messages
  typedef struct packed
  {
    mem_msg_e               msg_type;
    mem_size_e              size;
    logic [ADDR_W-1:0]      addr;
    logic [PAYLOAD_W-1:0]   payload;
  } mem_header_s;

  // AXI channel sequencer states
  typedef enum logic [2:0]
  {
    e_idle,
    e_wr_addr_data,
    e_wr_resp,
    e_rd_addr,
    e_rd_data,
    e_respond
  } chan_state_e;

endpackage

`default_nettype wire

//--- rtl/axil_xfer_if.sv
`timescale 1ns/10ps
`default_nettype none

interface axil_xfer_if;

  import mem_axil_pkg::*;

  // Command from decoder to sequencer
  logic [ADDR_W-1:0]      cmd_addr;
  logic [AXIL_DATA_W-1:0] cmd_wdata;
  logic [STRB_W-1:0]      cmd_wstrb;
  logic                   cmd_write;
  logic                   cmd_v;
  logic                   cmd_ready;

  // Response from sequencer to packer
  logic [AXIL_DATA_W-1:0] rsp_rdata;
  logic                   rsp_v;
  logic                   rsp_ready;

  modport issuer
  (
    output cmd_addr, cmd_wdata, cmd_wstrb, cmd_write, cmd_v,
    input  cmd_ready
  );

  modport sequencer
  (
    input  cmd_addr, cmd_wdata, cmd_wstrb, cmd_write, cmd_v, rsp_ready,
    output cmd_ready, rsp_rdata, rsp_v
  );

  modport collector
  (
    input  rsp_rdata, rsp_v,
    output rsp_ready
  );

endinterface

`default_nettype wire

//--- rtl/mem_fwd_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module mem_fwd_decoder
  (
    input  logic                              clk_i
  , input  logic                              reset_i

  , input  mem_axil_pkg::mem_header_s         mem_fwd_header_i
  , input  logic [mem_axil_pkg::FILL_W-1:0]   mem_fwd_data_i
  , input  logic                              mem_fwd_v_i
  , output logic                              mem_fwd_ready_and_o

  , axil_xfer_if.issuer                       xfer

  , output mem_axil_pkg::mem_header_s         held_header_o
  , output logic                              held_v_o
  , input  logic                              release_i
  );

  import mem_axil_pkg::*;

  mem_header_s        hdr_r;
  logic               hdr_v_r;
  logic               issued_r;
  logic [FILL_W-1:0]  wdata_r;
  logic [STRB_W-1:0]  size_mask;
  logic               fwd_hs;
  logic               cmd_hs;

  // Accept only while the single-entry buffer is empty
  assign mem_fwd_ready_and_o = ~hdr_v_r;
  assign fwd_hs              = mem_fwd_v_i & mem_fwd_ready_and_o;
  assign cmd_hs              = xfer.cmd_v & xfer.cmd_ready;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      hdr_v_r  <= 1'b0;
      issued_r <= 1'b0;
    end
    else if (fwd_hs)
    begin
      hdr_v_r  <= 1'b1;
      issued_r <= 1'b0;
    end
    else
    begin
      // Header stays until the reverse message leaves
      if (release_i)
        hdr_v_r <= 1'b0;
      if (cmd_hs)
        issued_r <= 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (fwd_hs)
    begin
      hdr_r   <= mem_fwd_header_i;
      wdata_r <= mem_fwd_data_i;
    end
  end

  // Low-aligned byte mask for the access size
  always_comb
  begin
    case (hdr_r.size)
      e_size_1: size_mask = STRB_W'(8'h01);
      e_size_2: size_mask = STRB_W'(8'h03);
      e_size_4: size_mask = STRB_W'(8'h0f);
      default:  size_mask = STRB_W'(8'hff);
    endcase
  end

  assign xfer.cmd_addr  = hdr_r.addr;
  assign xfer.cmd_wdata = wdata_r;
  assign xfer.cmd_wstrb = size_mask << hdr_r.addr[OFFS_W-1:0];
  assign xfer.cmd_write = hdr_r.msg_type inside {e_mem_wr, e_mem_uc_wr};
  // One command per accepted message
  assign xfer.cmd_v     = hdr_v_r & ~issued_r;

  assign held_header_o  = hdr_r;
  assign held_v_o       = hdr_v_r;

endmodule

`default_nettype wire

//--- rtl/axil_channel_master.sv
`timescale 1ns/10ps
`default_nettype none

module axil_channel_master
  (
    input  logic                                    clk_i
  , input  logic                                    reset_i

  , axil_xfer_if.sequencer                          xfer

  // Write address channel
  , output logic [mem_axil_pkg::ADDR_W-1:0]         m_axil_awaddr_o
  , output logic                                    m_axil_awvalid_o
  , input  logic                                    m_axil_awready_i

  // Write data channel
  , output logic [mem_axil_pkg::AXIL_DATA_W-1:0]    m_axil_wdata_o
  , output logic [mem_axil_pkg::STRB_W-1:0]         m_axil_wstrb_o
  , output logic                                    m_axil_wvalid_o
  , input  logic                                    m_axil_wready_i

  // Write response channel
  , input  logic [1:0]                              m_axil_bresp_i
  , input  logic                                    m_axil_bvalid_i
  , output logic                                    m_axil_bready_o

  // Read address channel
  , output logic [mem_axil_pkg::ADDR_W-1:0]         m_axil_araddr_o
  , output logic                                    m_axil_arvalid_o
  , input  logic                                    m_axil_arready_i

  // Read data channel
  , input  logic [mem_axil_pkg::AXIL_DATA_W-1:0]    m_axil_rdata_i
  , input  logic [1:0]                              m_axil_rresp_i
  , input  logic                                    m_axil_rvalid_i
  , output logic                                    m_axil_rready_o
  );

  import mem_axil_pkg::*;

  chan_state_e             state_r;
  chan_state_e             state_n;
  logic                    aw_done_r;
  logic                    w_done_r;
  logic [ADDR_W-1:0]       addr_r;
  logic [AXIL_DATA_W-1:0]  wdata_r;
  logic [STRB_W-1:0]       wstrb_r;
  logic [AXIL_DATA_W-1:0]  rdata_r;
  logic                    cmd_hs;
  logic                    aw_hs;
  logic                    w_hs;
  logic                    aw_fin;
  logic                    w_fin;

  assign cmd_hs = xfer.cmd_v & xfer.cmd_ready;
  assign aw_hs  = m_axil_awvalid_o & m_axil_awready_i;
  assign w_hs   = m_axil_wvalid_o & m_axil_wready_i;

  // AW and W may complete in either order
  assign aw_fin = aw_done_r | aw_hs;
  assign w_fin  = w_done_r | w_hs;

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      e_idle:
        if (cmd_hs)
          state_n = xfer.cmd_write ? e_wr_addr_data : e_rd_addr;
      e_wr_addr_data:
        if (aw_fin && w_fin)
          state_n = e_wr_resp;
      e_wr_resp:
        if (m_axil_bvalid_i)
          state_n = e_respond;
      e_rd_addr:
        if (m_axil_arready_i)
          state_n = e_rd_data;
      e_rd_data:
        if (m_axil_rvalid_i)
          state_n = e_respond;
      e_respond:
        if (xfer.rsp_ready)
          state_n = e_idle;
      default:
        state_n = e_idle;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r   <= e_idle;
      aw_done_r <= 1'b0;
      w_done_r  <= 1'b0;
    end
    else
    begin
      state_r <= state_n;
      if (cmd_hs)
      begin
        aw_done_r <= 1'b0;
        w_done_r  <= 1'b0;
      end
      else
      begin
        if (aw_hs)
          aw_done_r <= 1'b1;
        if (w_hs)
          w_done_r <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_hs)
    begin
      addr_r  <= xfer.cmd_addr;
      wdata_r <= xfer.cmd_wdata;
      wstrb_r <= xfer.cmd_wstrb;
    end
    if (m_axil_rvalid_i && m_axil_rready_o)
      rdata_r <= m_axil_rdata_i;
  end

  assign xfer.cmd_ready  = (state_r == e_idle);
  assign xfer.rsp_v      = (state_r == e_respond);
  assign xfer.rsp_rdata  = rdata_r;

  assign m_axil_awaddr_o  = addr_r;
  assign m_axil_awvalid_o = (state_r == e_wr_addr_data) & ~aw_done_r;
  assign m_axil_wdata_o   = wdata_r;
  assign m_axil_wstrb_o   = wstrb_r;
  assign m_axil_wvalid_o  = (state_r == e_wr_addr_data) & ~w_done_r;
  // Error responses are not reported upstream
  assign m_axil_bready_o  = (state_r == e_wr_resp);

  assign m_axil_araddr_o  = addr_r;
  assign m_axil_arvalid_o = (state_r == e_rd_addr);
  assign m_axil_rready_o  = (state_r == e_rd_data);

endmodule

`default_nettype wire

//--- rtl/mem_rev_packer.sv
`timescale 1ns/10ps
`default_nettype none

module mem_rev_packer
  (
    axil_xfer_if.collector                    xfer

  , input  mem_axil_pkg::mem_header_s         held_header_i
  , input  logic                              held_v_i
  , output logic                              release_o

  , output mem_axil_pkg::mem_header_s         mem_rev_header_o
  , output logic [mem_axil_pkg::FILL_W-1:0]   mem_rev_data_o
  , output logic                              mem_rev_v_o
  , input  logic                              mem_rev_ready_and_i
  );

  import mem_axil_pkg::*;

  logic [OFFS_W-1:0]       offs;
  logic [AXIL_DATA_W-1:0]  shifted;
  logic                    rev_hs;

  // Move the addressed bytes down to bit 0
  assign offs    = held_header_i.addr[OFFS_W-1:0];
  assign shifted = xfer.rsp_rdata >> {offs, 3'b000};

  // Replicate the selected group across the fill word
  always_comb
  begin
    case (held_header_i.size)
      e_size_1: mem_rev_data_o = {(FILL_W/8){shifted[7:0]}};
      e_size_2: mem_rev_data_o = {(FILL_W/16){shifted[15:0]}};
      e_size_4: mem_rev_data_o = {(FILL_W/32){shifted[31:0]}};
      default:  mem_rev_data_o = shifted;
    endcase
  end

  assign mem_rev_header_o = held_header_i;
  assign mem_rev_v_o      = xfer.rsp_v & held_v_i;

  // Response and header retire together
  assign rev_hs         = mem_rev_v_o & mem_rev_ready_and_i;
  assign xfer.rsp_ready = rev_hs;
  assign release_o      = rev_hs;

endmodule

`default_nettype wire

//--- rtl/mem_axil_bridge.sv
`timescale 1ns/10ps
`default_nettype none

module mem_axil_bridge
  (
    input  logic                                    clk_i
  , input  logic                                    reset_i

  // Memory forward
  , input  mem_axil_pkg::mem_header_s               mem_fwd_header_i
  , input  logic [mem_axil_pkg::FILL_W-1:0]         mem_fwd_data_i
  , input  logic                                    mem_fwd_v_i
  , output logic                                    mem_fwd_ready_and_o

  // Memory reverse
  , output mem_axil_pkg::mem_header_s               mem_rev_header_o
  , output logic [mem_axil_pkg::FILL_W-1:0]         mem_rev_data_o
  , output logic                                    mem_rev_v_o
  , input  logic                                    mem_rev_ready_and_i

  // AXI4-Lite master
  , output logic [mem_axil_pkg::ADDR_W-1:0]         m_axil_awaddr_o
  , output logic                                    m_axil_awvalid_o
  , input  logic                                    m_axil_awready_i

  , output logic [mem_axil_pkg::AXIL_DATA_W-1:0]    m_axil_wdata_o
  , output logic [mem_axil_pkg::STRB_W-1:0]         m_axil_wstrb_o
  , output logic                                    m_axil_wvalid_o
  , input  logic                                    m_axil_wready_i

  , input  logic [1:0]                              m_axil_bresp_i
  , input  logic                                    m_axil_bvalid_i
  , output logic                                    m_axil_bready_o

  , output logic [mem_axil_pkg::ADDR_W-1:0]         m_axil_araddr_o
  , output logic                                    m_axil_arvalid_o
  , input  logic                                    m_axil_arready_i

  , input  logic [mem_axil_pkg::AXIL_DATA_W-1:0]    m_axil_rdata_i
  , input  logic [1:0]                              m_axil_rresp_i
  , input  logic                                    m_axil_rvalid_i
  , output logic                                    m_axil_rready_o
  );

  import mem_axil_pkg::*;

  mem_header_s  held_header;
  logic         held_v;
  logic         hdr_release;

  axil_xfer_if xfer ();

  mem_fwd_decoder decoder
  (
    .clk_i                (clk_i)
  , .reset_i              (reset_i)
  , .mem_fwd_header_i     (mem_fwd_header_i)
  , .mem_fwd_data_i       (mem_fwd_data_i)
  , .mem_fwd_v_i          (mem_fwd_v_i)
  , .mem_fwd_ready_and_o  (mem_fwd_ready_and_o)
  , .xfer                 (xfer.issuer)
  , .held_header_o        (held_header)
  , .held_v_o             (held_v)
  , .release_i            (hdr_release)
  );

  axil_channel_master sequencer
  (
    .clk_i             (clk_i)
  , .reset_i           (reset_i)
  , .xfer              (xfer.sequencer)
  , .m_axil_awaddr_o   (m_axil_awaddr_o)
  , .m_axil_awvalid_o  (m_axil_awvalid_o)
  , .m_axil_awready_i  (m_axil_awready_i)
  , .m_axil_wdata_o    (m_axil_wdata_o)
  , .m_axil_wstrb_o    (m_axil_wstrb_o)
  , .m_axil_wvalid_o   (m_axil_wvalid_o)
  , .m_axil_wready_i   (m_axil_wready_i)
  , .m_axil_bresp_i    (m_axil_bresp_i)
  , .m_axil_bvalid_i   (m_axil_bvalid_i)
  , .m_axil_bready_o   (m_axil_bready_o)
  , .m_axil_araddr_o   (m_axil_araddr_o)
  , .m_axil_arvalid_o  (m_axil_arvalid_o)
  , .m_axil_arready_i  (m_axil_arready_i)
  , .m_axil_rdata_i    (m_axil_rdata_i)
  , .m_axil_rresp_i    (m_axil_rresp_i)
  , .m_axil_rvalid_i   (m_axil_rvalid_i)
  , .m_axil_rready_o   (m_axil_rready_o)
  );

  mem_rev_packer packer
  (
    .xfer                 (xfer.collector)
  , .held_header_i        (held_header)
  , .held_v_i             (held_v)
  , .release_o            (hdr_release)
  , .mem_rev_header_o     (mem_rev_header_o)
  , .mem_rev_data_o       (mem_rev_data_o)
  , .mem_rev_v_o          (mem_rev_v_o)
  , .mem_rev_ready_and_i  (mem_rev_ready_and_i)
  );

endmodule

`default_nettype wire

//--- tests/tb_axil_memory.sv
`timescale 1ns/10ps
`default_nettype none

module tb_axil_memory
  (
    input  logic                                    clk_i
  , input  logic                                    reset_i
  // Stall bits for AW, W, B, AR and R from bit 0 up
  , input  logic [4:0]                              stall_i

  , input  logic [mem_axil_pkg::ADDR_W-1:0]         awaddr_i
  , input  logic                                    awvalid_i
  , output logic                                    awready_o
  , input  logic [mem_axil_pkg::AXIL_DATA_W-1:0]    wdata_i
  , input  logic [mem_axil_pkg::STRB_W-1:0]         wstrb_i
  , input  logic                                    wvalid_i
  , output logic                                    wready_o
  , output logic [1:0]                              bresp_o
  , output logic                                    bvalid_o
  , input  logic                                    bready_i

  , input  logic [mem_axil_pkg::ADDR_W-1:0]         araddr_i
  , input  logic                                    arvalid_i
  , output logic                                    arready_o
  , output logic [mem_axil_pkg::AXIL_DATA_W-1:0]    rdata_o
  , output logic [1:0]                              rresp_o
  , output logic                                    rvalid_o
  , input  logic                                    rready_i

  , output logic [mem_axil_pkg::STRB_W-1:0]         last_wstrb_o
  , output logic [31:0]                             wr_count_o
  );

  import mem_axil_pkg::*;

  logic [7:0]              mem [0:255];
  logic                    aw_got_r;
  logic                    w_got_r;
  logic                    ar_got_r;
  logic [ADDR_W-1:0]       awaddr_r;
  logic [ADDR_W-1:0]       araddr_r;
  logic [AXIL_DATA_W-1:0]  wdata_r;
  logic [STRB_W-1:0]       wstrb_r;

  assign awready_o = ~aw_got_r & ~stall_i[0];
  assign wready_o  = ~w_got_r & ~stall_i[1];
  assign arready_o = ~ar_got_r & ~rvalid_o & ~stall_i[3];
  assign bresp_o   = 2'b00;
  assign rresp_o   = 2'b00;

  always @(posedge clk_i)
  begin
    if (reset_i)
    begin
      aw_got_r   <= 1'b0;
      w_got_r    <= 1'b0;
      ar_got_r   <= 1'b0;
      bvalid_o   <= 1'b0;
      rvalid_o   <= 1'b0;
      wr_count_o <= '0;
      for (int i = 0; i < 256; i++)
        mem[i] <= 8'(i * 37 + 11);
    end
    else
    begin
      if (awvalid_i && awready_o)
      begin
        aw_got_r <= 1'b1;
        awaddr_r <= awaddr_i;
      end
      if (wvalid_i && wready_o)
      begin
        w_got_r <= 1'b1;
        wdata_r <= wdata_i;
        wstrb_r <= wstrb_i;
      end
      // Commit once address and data are both held
      if (aw_got_r && w_got_r && !bvalid_o && !stall_i[2])
      begin
        for (int k = 0; k < STRB_W; k++)
          if (wstrb_r[k])
            mem[{awaddr_r[7:3], 3'(k)}] <= wdata_r[k*8 +: 8];
        last_wstrb_o <= wstrb_r;
        wr_count_o   <= wr_count_o + 1;
        bvalid_o     <= 1'b1;
      end
      if (bvalid_o && bready_i)
      begin
        bvalid_o <= 1'b0;
        aw_got_r <= 1'b0;
        w_got_r  <= 1'b0;
      end
      if (arvalid_i && arready_o)
      begin
        ar_got_r <= 1'b1;
        araddr_r <= araddr_i;
      end
      // Whole aligned word goes back
      if (ar_got_r && !stall_i[4])
      begin
        for (int k = 0; k < STRB_W; k++)
          rdata_o[k*8 +: 8] <= mem[{araddr_r[7:3], 3'(k)}];
        rvalid_o <= 1'b1;
        ar_got_r <= 1'b0;
      end
      if (rvalid_o && rready_i)
        rvalid_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- tests/tb_mem_axil_bridge.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mem_axil_bridge;

  import mem_axil_pkg::*;

  localparam int NUM_REQS = 400;
  localparam int WAIT_MAX = 500;
  localparam logic [ADDR_W-1:0] BASE_ADDR = 32'h4000_1000;

  logic                    clk_i = 1'b0;
  logic                    reset_i;
  mem_header_s             mem_fwd_header_i;
  logic [FILL_W-1:0]       mem_fwd_data_i;
  logic                    mem_fwd_v_i;
  logic                    mem_fwd_ready_and_o;
  mem_header_s             mem_rev_header_o;
  logic [FILL_W-1:0]       mem_rev_data_o;
  logic                    mem_rev_v_o;
  logic                    mem_rev_ready_and_i;
  logic [ADDR_W-1:0]       m_axil_awaddr_o;
  logic [ADDR_W-1:0]       m_axil_araddr_o;
  logic [AXIL_DATA_W-1:0]  m_axil_wdata_o;
  logic [AXIL_DATA_W-1:0]  m_axil_rdata_i;
  logic [STRB_W-1:0]       m_axil_wstrb_o;
  logic [1:0]              m_axil_bresp_i;
  logic [1:0]              m_axil_rresp_i;
  logic                    m_axil_awvalid_o;
  logic                    m_axil_awready_i;
  logic                    m_axil_wvalid_o;
  logic                    m_axil_wready_i;
  logic                    m_axil_bvalid_i;
  logic                    m_axil_bready_o;
  logic                    m_axil_arvalid_o;
  logic                    m_axil_arready_i;
  logic                    m_axil_rvalid_i;
  logic                    m_axil_rready_o;

  logic [4:0]              stall_bits;
  logic [STRB_W-1:0]       last_wstrb;
  logic [31:0]             wr_count;
  logic [31:0]             rng_state = 32'h53e276b2;
  logic [7:0]              ref_mem [0:255];
  mem_header_s             next_hdr;
  logic [FILL_W-1:0]       next_data;
  logic                    next_v;

  always #10 clk_i = ~clk_i;

  mem_axil_bridge mem_axil_bridge_i (.*);

  tb_axil_memory axil_mem
  (
    .clk_i (clk_i), .reset_i (reset_i), .stall_i (stall_bits)
  , .awaddr_i (m_axil_awaddr_o), .awvalid_i (m_axil_awvalid_o), .awready_o (m_axil_awready_i)
  , .wdata_i (m_axil_wdata_o), .wstrb_i (m_axil_wstrb_o), .wvalid_i (m_axil_wvalid_o)
  , .wready_o (m_axil_wready_i), .bresp_o (m_axil_bresp_i), .bvalid_o (m_axil_bvalid_i)
  , .bready_i (m_axil_bready_o), .araddr_i (m_axil_araddr_o), .arvalid_i (m_axil_arvalid_o)
  , .arready_o (m_axil_arready_i), .rdata_o (m_axil_rdata_i), .rresp_o (m_axil_rresp_i)
  , .rvalid_o (m_axil_rvalid_i), .rready_i (m_axil_rready_o)
  , .last_wstrb_o (last_wstrb), .wr_count_o (wr_count)
  );

  function automatic logic [31:0] xorshift();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic run_failed();
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [63:0] actual, input logic [63:0] expected);
    if (actual !== expected)
    begin
      $display("Error: %s is %h, expected %h", name, actual, expected);
      run_failed();
    end
  endtask

  task automatic timeout_abort(input string what);
    $display("Timeout while waiting for %s", what);
    run_failed();
  endtask

  // Drive new inputs after the edge and return at the falling edge for sampling
  task automatic tick();
    logic [31:0] r;
    @(posedge clk_i);
    #1;
    r = xorshift();
    stall_bits          = {&r[9:8], &r[7:6], &r[5:4], &r[3:2], &r[1:0]};
    mem_rev_ready_and_i = |r[11:10];
    mem_fwd_header_i    = next_hdr;
    mem_fwd_data_i      = next_data;
    mem_fwd_v_i         = next_v;
    @(negedge clk_i);
  endtask

  initial
  begin
    mem_header_s        hdr;
    logic [FILL_W-1:0]  data;
    logic [63:0]        group;
    logic [FILL_W-1:0]  exp_data;
    logic [31:0]        r;
    logic [7:0]         lo;
    logic [STRB_W-1:0]  exp_strb;
    int                 nbytes;
    int                 waited;
    int                 writes;

    reset_i             = 1'b1;
    mem_fwd_header_i    = '0;
    mem_fwd_data_i      = '0;
    mem_fwd_v_i         = 1'b0;
    mem_rev_ready_and_i = 1'b0;
    stall_bits          = '0;
    next_hdr            = '0;
    next_data           = '0;
    next_v              = 1'b0;
    writes              = 0;
    repeat (4) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    @(negedge clk_i);
    check("mem_rev_v_o", 64'(mem_rev_v_o), 64'(0));
    check("m_axil_awvalid_o", 64'(m_axil_awvalid_o), 64'(0));
    check("m_axil_wvalid_o", 64'(m_axil_wvalid_o), 64'(0));
    check("m_axil_bready_o", 64'(m_axil_bready_o), 64'(0));
    check("m_axil_arvalid_o", 64'(m_axil_arvalid_o), 64'(0));
    check("m_axil_rready_o", 64'(m_axil_rready_o), 64'(0));
    check("mem_fwd_ready_and_o", 64'(mem_fwd_ready_and_o), 64'(1));
    for (int i = 0; i < 256; i++)
      ref_mem[i] = axil_mem.mem[i];

    for (int n = 0; n < NUM_REQS; n++)
    begin
      r            = xorshift();
      hdr.msg_type = mem_msg_e'(r[1:0]);
      hdr.size     = mem_size_e'(r[3:2]);
      hdr.payload  = r[19:12];
      nbytes       = 1 << r[3:2];
      lo           = r[11:4] & ~8'(nbytes - 1);
      hdr.addr     = BASE_ADDR | {24'h0, lo};
      group        = {xorshift(), xorshift()};
      // Sender replicates the written group across the fill word
      for (int k = 0; k < 8; k++)
        data[k*8 +: 8] = group[(k % nbytes)*8 +: 8];
      next_hdr  = hdr;
      next_data = data;
      next_v    = 1'b1;

      waited = 0;
      do
      begin
        tick();
        waited++;
        check("mem_rev_v_o", 64'(mem_rev_v_o), 64'(0));
        if (waited > WAIT_MAX)
          timeout_abort("the forward ready");
      end
      while (!mem_fwd_ready_and_o);

      next_v = 1'b0;
      waited = 0;
      do
      begin
        tick();
        waited++;
        check("mem_fwd_ready_and_o", 64'(mem_fwd_ready_and_o), 64'(0));
        if (waited > WAIT_MAX)
          timeout_abort("the reverse message");
      end
      while (!(mem_rev_v_o && mem_rev_ready_and_i));

      check("mem_rev_header_o", 64'(mem_rev_header_o), 64'(hdr));
      if (hdr.msg_type inside {e_mem_wr, e_mem_uc_wr})
      begin
        writes++;
        exp_strb = 8'(((1 << nbytes) - 1) << lo[2:0]);
        for (int k = 0; k < nbytes; k++)
          ref_mem[int'(lo) + k] = data[(int'(lo[2:0]) + k)*8 +: 8];
        check("m_axil_awaddr_o", 64'(axil_mem.awaddr_r), 64'(hdr.addr));
        check("m_axil_wstrb_o", 64'(last_wstrb), 64'(exp_strb));
        check("write count", 64'(wr_count), 64'(writes));
        for (int i = 0; i < 256; i++)
          check($sformatf("memory byte %0d", i), 64'(axil_mem.mem[i]), 64'(ref_mem[i]));
      end
      else
      begin
        check("m_axil_araddr_o", 64'(axil_mem.araddr_r), 64'(hdr.addr));
        for (int k = 0; k < 8; k++)
          exp_data[k*8 +: 8] = ref_mem[int'(lo) + (k % nbytes)];
        check("mem_rev_data_o", mem_rev_data_o, exp_data);
      end
    end

    // No extra reverse message after the last request
    repeat (4)
    begin
      tick();
      check("mem_rev_v_o", 64'(mem_rev_v_o), 64'(0));
    end
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
rtl/mem_axil_pkg.sv
rtl/axil_xfer_if.sv
rtl/mem_fwd_decoder.sv
rtl/axil_channel_master.sv
rtl/mem_rev_packer.sv
rtl/mem_axil_bridge.sv
tests/tb_axil_memory.sv
tests/tb_mem_axil_bridge.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps \
  --top-module tb_mem_axil_bridge -f flist.f

sim_out=$(./obj_dir/Vtb_mem_axil_bridge 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx 'RESULT: PASS'
then
  exit 0
fi
exit 1
